// ==== Makefile ====
SIM       = verilator
SIM_FLAGS = --binary --timing
TOP       = instr_decoder_tb
FILE_LIST = all.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for a pass"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
hdl/rv_decode_pkg.sv
hdl/decode_control.sv
hdl/imm_gen.sv
hdl/mem_access_decode.sv
hdl/branch_decode.sv
hdl/instr_decoder.sv
testbench/tb_clock.sv
testbench/instr_decoder_tb.sv

// ==== hdl/branch_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module branch_decode
    import rv_decode_pkg::*;
(
    input  wire logic [2:0] funct3_i,
    input  wire logic       is_branch_i,
    input  wire logic       jump_i,
    input  wire logic       branch_i,                       // Taken level from execute
    output br_op_e          br_op_o,
    output logic            brj_o
);

    always_comb begin
        br_op_o = BR_NOOP;
        if (is_branch_i) begin
            case (funct3_i)
                3'b000:  br_op_o = BR_EQ;
                3'b001:  br_op_o = BR_NE;
                3'b100:  br_op_o = BR_LT;
                3'b101:  br_op_o = BR_GE;
                3'b110:  br_op_o = BR_LTU;
                3'b111:  br_op_o = BR_GEU;
                default: br_op_o = BR_NOOP;                 // funct3 2 and 3 are reserved
            endcase
        end
    end

    assign brj_o = branch_i | jump_i;                       // Redirect fetch on taken branch or jump

endmodule

`default_nettype wire

// ==== hdl/decode_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_control
    import rv_decode_pkg::*;
(
    input  wire logic [XLEN-1:0]       instr_i,
    output alu_op_t                    alu_op_o,
    output data_origin_e               data_origin_o,
    output logic [1:0]                 data_target_o,       // 3 for PC/imm results, 1 for stores
    output logic                       regfile_wr_o,
    output logic [REG_ADDR_W-1:0]      regfile_raddr_rs1_o,
    output logic [REG_ADDR_W-1:0]      regfile_raddr_rs2_o,
    output logic [REG_ADDR_W-1:0]      regfile_waddr_o,
    output logic                       data_rd_o,
    output logic                       data_wr_o,
    output logic                       is_load_store_o,
    output logic                       i_r1_o,              // rs1 is read
    output logic                       i_r2_o,              // rs2 is read
    output logic                       jalr_o,
    output logic                       jump_o,
    output logic                       is_branch_o,
    output logic                       is_load_o,
    output logic                       is_store_o,
    output imm_fmt_e                   imm_fmt_o,
    output logic                       csr_wr_o,
    output csr_op_t                    csr_op_o,
    output logic [CSR_ADDR_W-1:0]      csr_raddr_o,
    output logic [REG_ADDR_W-1:0]      csr_imm_o            // Zimm lives in the rs1 field
);

    opcode_e      opcode;
    logic [2:0]   funct3;
    logic         rd_nz;                                    // Writes to x0 are dropped

    assign opcode              = opcode_e'(instr_i[6:0]);
    assign funct3              = instr_i[14:12];
    assign regfile_raddr_rs1_o = instr_i[19:15];
    assign regfile_raddr_rs2_o = instr_i[24:20];
    assign regfile_waddr_o     = instr_i[11:7];
    assign rd_nz               = |instr_i[11:7];
    assign csr_raddr_o         = instr_i[31:20];
    assign csr_imm_o           = instr_i[19:15];

    always_comb begin
        alu_op_o        = ALU_OP_ADD;                       // Everything but OP/OP-IMM adds
        data_origin_o   = REGS;
        data_target_o   = 2'd0;
        regfile_wr_o    = 1'b0;
        data_rd_o       = 1'b0;
        data_wr_o       = 1'b0;
        is_load_store_o = 1'b0;
        i_r1_o          = 1'b0;
        i_r2_o          = 1'b0;
        jalr_o          = 1'b0;
        jump_o          = 1'b0;
        is_branch_o     = 1'b0;
        is_load_o       = 1'b0;
        is_store_o      = 1'b0;
        imm_fmt_o       = IMM_NONE;
        csr_wr_o        = 1'b0;
        csr_op_o        = '0;
        case (opcode)
            OPC_LUI: begin                                  // rd = 0 + imm
                data_origin_o = RS2IMM_RS1;
                data_target_o = 2'd3;
                imm_fmt_o     = IMM_U;
                regfile_wr_o  = rd_nz;
            end
            OPC_AUIPC: begin                                // rd = PC + imm
                data_origin_o = RS2IMM_RS1PC;
                data_target_o = 2'd3;
                imm_fmt_o     = IMM_U;
                regfile_wr_o  = rd_nz;
            end
            OPC_JAL: begin                                  // Target is PC + imm
                data_origin_o = RS2IMM_RS1PC;
                data_target_o = 2'd3;
                imm_fmt_o     = IMM_J;
                jump_o        = 1'b1;
                regfile_wr_o  = rd_nz;
            end
            OPC_JALR: begin                                 // Target is rs1 + imm
                data_origin_o = RS2IMM_RS1PC;
                data_target_o = 2'd3;
                imm_fmt_o     = IMM_I;
                i_r1_o        = 1'b1;
                jump_o        = 1'b1;
                jalr_o        = 1'b1;
                regfile_wr_o  = rd_nz;
            end
            OPC_BRANCH: begin                               // Compare rs1 with rs2
                imm_fmt_o   = IMM_B;
                i_r1_o      = 1'b1;
                i_r2_o      = 1'b1;
                is_branch_o = 1'b1;
            end
            OPC_LOAD: begin                                 // Address is rs1 + imm
                data_origin_o   = RS2IMM_RS1;
                imm_fmt_o       = IMM_I;
                i_r1_o          = 1'b1;
                data_rd_o       = 1'b1;
                is_load_store_o = 1'b1;
                is_load_o       = 1'b1;
                regfile_wr_o    = rd_nz;
            end
            OPC_STORE: begin
                data_origin_o   = RS2IMM_RS1;
                data_target_o   = 2'd1;
                imm_fmt_o       = IMM_S;
                i_r1_o          = 1'b1;
                i_r2_o          = 1'b1;                     // Store data
                data_wr_o       = 1'b1;
                is_load_store_o = 1'b1;
                is_store_o      = 1'b1;
            end
            OPC_IMM: begin                                  // Imm bits 25 and 30 stand in for funct7
                data_origin_o = RS2IMM_RS1;
                imm_fmt_o     = IMM_I;
                i_r1_o        = 1'b1;
                alu_op_o      = {instr_i[25], instr_i[30], funct3};
                regfile_wr_o  = rd_nz;
            end
            OPC_REG: begin
                i_r1_o       = 1'b1;
                i_r2_o       = 1'b1;
                alu_op_o     = {instr_i[25], instr_i[30], funct3}; // funct7[0] flags MUL/DIV
                regfile_wr_o = rd_nz;
            end
            OPC_FENCE: begin
                // No effect in this pipeline, all defaults
            end
            OPC_SYSTEM: begin
                csr_wr_o     = |funct3;                     // Zero funct3 is ECALL/EBREAK
                regfile_wr_o = rd_nz & (|funct3);           // Old CSR value goes to rd
                csr_op_o     = funct3;
                i_r1_o       = ~funct3[2];                  // Immediate forms skip rs1
            end
            default: begin
                // Unknown opcode keeps all defaults
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/imm_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module imm_gen
    import rv_decode_pkg::*;
#(
    parameter int XLEN = rv_decode_pkg::XLEN
) (
    input  wire logic [XLEN-1:0] instr_i,
    input  imm_fmt_e             imm_fmt_i,
    output logic [XLEN-1:0]      imm_o
);

    logic signed [31:0] u_imm;                              // Upper immediate before widening

    assign u_imm = {instr_i[31:12], 12'b0};

    always_comb begin
        case (imm_fmt_i)
            IMM_I: imm_o = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
            IMM_S: imm_o = {{(XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            IMM_B: imm_o = {{(XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                            instr_i[30:25], instr_i[11:8], 1'b0};      // Halfword aligned
            IMM_U: imm_o = XLEN'(u_imm);                    // Sign fill only beyond 32 bits
            IMM_J: imm_o = {{(XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
                            instr_i[20], instr_i[30:21], 1'b0};
            default: imm_o = '0;                            // IMM_NONE
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/instr_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_decoder
    import rv_decode_pkg::*;
#(
    parameter int XLEN = rv_decode_pkg::XLEN
) (
    input  wire logic [XLEN-1:0]       instr_i,
    input  wire logic                  branch_i,
    output alu_op_t                    alu_op_o,
    output data_origin_e               data_origin_o,
    output logic [1:0]                 data_target_o,
    output logic                       regfile_wr_o,
    output logic [REG_ADDR_W-1:0]      regfile_raddr_rs1_o,
    output logic [REG_ADDR_W-1:0]      regfile_raddr_rs2_o,
    output logic [REG_ADDR_W-1:0]      regfile_waddr_o,
    output logic                       data_rd_o,
    output logic                       data_wr_o,
    output logic                       is_load_store_o,
    output logic                       i_r1_o,
    output logic                       i_r2_o,
    output logic                       jalr_o,
    output logic [XLEN-1:0]            imm_val_o,
    output load_op_e                   load_op_o,
    output store_op_e                  store_op_o,
    output logic [BE_W-1:0]            data_be_o,
    output br_op_e                     br_op_o,
    output logic                       brj_o,
    output logic                       csr_wr_o,
    output csr_op_t                    csr_op_o,
    output logic [CSR_ADDR_W-1:0]      csr_raddr_o,
    output logic [REG_ADDR_W-1:0]      csr_imm_o
);

    imm_fmt_e imm_fmt;                                      // Immediate layout for imm_gen
    logic     is_load;
    logic     is_store;
    logic     is_branch;
    logic     jump;

    decode_control i_decode_control (
        .instr_i             (instr_i),
        .alu_op_o            (alu_op_o),
        .data_origin_o       (data_origin_o),
        .data_target_o       (data_target_o),
        .regfile_wr_o        (regfile_wr_o),
        .regfile_raddr_rs1_o (regfile_raddr_rs1_o),
        .regfile_raddr_rs2_o (regfile_raddr_rs2_o),
        .regfile_waddr_o     (regfile_waddr_o),
        .data_rd_o           (data_rd_o),
        .data_wr_o           (data_wr_o),
        .is_load_store_o     (is_load_store_o),
        .i_r1_o              (i_r1_o),
        .i_r2_o              (i_r2_o),
        .jalr_o              (jalr_o),
        .jump_o              (jump),
        .is_branch_o         (is_branch),
        .is_load_o           (is_load),
        .is_store_o          (is_store),
        .imm_fmt_o           (imm_fmt),
        .csr_wr_o            (csr_wr_o),
        .csr_op_o            (csr_op_o),
        .csr_raddr_o         (csr_raddr_o),
        .csr_imm_o           (csr_imm_o)
    );

    imm_gen #(
        .XLEN (XLEN)
    ) i_imm_gen (
        .instr_i   (instr_i),
        .imm_fmt_i (imm_fmt),
        .imm_o     (imm_val_o)
    );

    mem_access_decode i_mem_access_decode (
        .funct3_i   (instr_i[14:12]),                       // funct3 field
        .is_load_i  (is_load),
        .is_store_i (is_store),
        .load_op_o  (load_op_o),
        .store_op_o (store_op_o),
        .data_be_o  (data_be_o)
    );

    branch_decode i_branch_decode (
        .funct3_i    (instr_i[14:12]),
        .is_branch_i (is_branch),
        .jump_i      (jump),
        .branch_i    (branch_i),
        .br_op_o     (br_op_o),
        .brj_o       (brj_o)
    );

endmodule

`default_nettype wire

// ==== hdl/mem_access_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_access_decode
    import rv_decode_pkg::*;
(
    input  wire logic [2:0]  funct3_i,
    input  wire logic        is_load_i,
    input  wire logic        is_store_i,
    output load_op_e         load_op_o,
    output store_op_e        store_op_o,
    output logic [BE_W-1:0]  data_be_o
);

    always_comb begin
        load_op_o  = LOAD_LW;
        store_op_o = STORE_SB;
        data_be_o  = '0;                                    // No bytes written
        if (is_load_i) begin
            case (funct3_i)
                3'b000:  load_op_o = LOAD_LB;
                3'b001:  load_op_o = LOAD_LH;
                3'b010:  load_op_o = LOAD_LW;
                3'b100:  load_op_o = LOAD_LBU;
                3'b101:  load_op_o = LOAD_LHU;
                default: load_op_o = LOAD_LW;               // Illegal width, no trap
            endcase
        end else if (is_store_i) begin
            case (funct3_i)
                3'b000: begin                               // Byte
                    store_op_o = STORE_SB;
                    data_be_o  = 4'b0001;
                end
                3'b001: begin                               // Halfword
                    store_op_o = STORE_SH;
                    data_be_o  = 4'b0011;
                end
                3'b010: begin                               // Word
                    store_op_o = STORE_SW;
                    data_be_o  = 4'b1111;
                end
                default: begin
                    store_op_o = STORE_SB;                  // Illegal width writes nothing
                    data_be_o  = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rv_decode_pkg.sv ====
`default_nettype none

package rv_decode_pkg;

    localparam int XLEN       = 32;              // Data and instruction width
    localparam int REG_ADDR_W = 5;               // x0..x31
    localparam int CSR_ADDR_W = 12;              // Full CSR address space
    localparam int BE_W       = 4;               // One enable per byte of a word

    // {M-extension bit, alternate bit, funct3}
    typedef logic [4:0] alu_op_t;

    localparam alu_op_t ALU_OP_ADD = 5'b00000;   // Plain add, used for address and PC math

    // Bit 2 selects immediate source, bits 1:0 give RW/RS/RC
    typedef logic [2:0] csr_op_t;

    // Major opcodes of the base ISA
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_IMM    = 7'b0010011,                 // Register-immediate ALU
        OPC_REG    = 7'b0110011,                 // Register-register ALU and M extension
        OPC_FENCE  = 7'b0001111,
        OPC_SYSTEM = 7'b1110011                  // ECALL/EBREAK and CSR access
    } opcode_e;

    typedef enum logic [2:0] {
        BR_NOOP = 3'd0,                          // Not a branch or reserved funct3
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_LTU  = 3'd4,
        BR_GE   = 3'd5,
        BR_GEU  = 3'd6
    } br_op_e;

    typedef enum logic [2:0] {
        LOAD_LB  = 3'd0,
        LOAD_LH  = 3'd1,
        LOAD_LW  = 3'd2,                         // Default when no load
        LOAD_LBU = 3'd3,
        LOAD_LHU = 3'd4
    } load_op_e;

    typedef enum logic [1:0] {
        STORE_SB = 2'd0,                         // Default when no store
        STORE_SH = 2'd1,
        STORE_SW = 2'd2
    } store_op_e;

    // Operand selection for the execute unit
    typedef enum logic [1:0] {
        REGS         = 2'd0,                     // rs1 and rs2
        RS2IMM_RS1   = 2'd1,                     // rs1 and immediate
        RS2IMM_RS1PC = 2'd2                      // PC and immediate
    } data_origin_e;

    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_I    = 3'd1,
        IMM_S    = 3'd2,
        IMM_B    = 3'd3,
        IMM_U    = 3'd4,
        IMM_J    = 3'd5
    } imm_fmt_e;

endpackage

`default_nettype wire

// ==== testbench/decode_stimulus.txt ====
# tag instr branch_i | alu org tgt rf_wr rs1 rs2 rd d_rd d_wr ls i_r1 i_r2 jalr imm
#   load store be br_op brj csr_wr csr_op csr_addr csr_imm  (all fields hex)
add      002081b3 0 00 0 0 1 01 02 03 0 0 0 1 1 0 00000000 2 0 0 0 0 0 0 002 01
sub      407302b3 0 08 0 0 1 06 07 05 0 0 0 1 1 0 00000000 2 0 0 0 0 0 0 407 06
mul      02c58533 0 10 0 0 1 0b 0c 0a 0 0 0 1 1 0 00000000 2 0 0 0 0 0 0 02c 0b
add_x0   00208033 0 00 0 0 0 01 02 00 0 0 0 1 1 0 00000000 2 0 0 0 0 0 0 002 01
addi     00510093 0 00 1 0 1 02 05 01 0 0 0 1 0 0 00000005 2 0 0 0 0 0 0 005 02
addi_b30 40020213 0 08 1 0 1 04 00 04 0 0 0 1 0 0 00000400 2 0 0 0 0 0 0 400 04
andi_neg fff47393 0 1f 1 0 1 08 1f 07 0 0 0 1 0 0 ffffffff 2 0 0 0 0 0 0 fff 08
lui      123452b7 0 00 1 3 1 08 03 05 0 0 0 0 0 0 12345000 2 0 0 0 0 0 0 123 08
auipc    fffff097 0 00 2 3 1 1f 1f 01 0 0 0 0 0 0 fffff000 2 0 0 0 0 0 0 fff 1f
jal      ffdff0ef 0 00 2 3 1 1f 1d 01 0 0 0 0 0 0 fffffffc 2 0 0 0 1 0 0 ffd 1f
jalr     004100e7 0 00 2 3 1 02 04 01 0 0 0 1 0 1 00000004 2 0 0 0 1 0 0 004 02
beq      00208463 0 00 0 0 0 01 02 08 0 0 0 1 1 0 00000008 2 0 0 1 0 0 0 002 01
bne_tk   fe419ee3 1 00 0 0 0 03 04 1d 0 0 0 1 1 0 fffffffc 2 0 0 2 1 0 0 fe4 03
bltu     0020e463 0 00 0 0 0 01 02 08 0 0 0 1 1 0 00000008 2 0 0 4 0 0 0 002 01
br_f3_2  0020a463 0 00 0 0 0 01 02 08 0 0 0 1 1 0 00000008 2 0 0 0 0 0 0 002 01
lw       00812283 0 00 1 0 1 02 08 05 1 0 1 1 0 0 00000008 2 0 0 0 0 0 0 008 02
lbu      fff3c303 0 00 1 0 1 07 1f 06 1 0 1 1 0 0 ffffffff 3 0 0 0 0 0 0 fff 07
ld_bad   00813283 0 00 1 0 1 02 08 05 1 0 1 1 0 0 00000008 2 0 0 0 0 0 0 008 02
sw       00512623 0 00 1 1 0 02 05 0c 0 1 1 1 1 0 0000000c 2 2 f 0 0 0 0 005 02
sb       fe118f23 0 00 1 1 0 03 01 1e 0 1 1 1 1 0 fffffffe 2 0 1 0 0 0 0 fe1 03
st_bad   00113023 0 00 1 1 0 02 01 00 0 1 1 1 1 0 00000000 2 0 0 0 0 0 0 001 02
csrrw    300110f3 0 00 0 0 1 02 00 01 0 0 0 1 0 0 00000000 2 0 0 0 0 1 1 300 02
csrrci   3413f2f3 0 00 0 0 1 07 01 05 0 0 0 0 0 0 00000000 2 0 0 0 0 1 7 341 07
ecall    00000073 0 00 0 0 0 00 00 00 0 0 0 1 0 0 00000000 2 0 0 0 0 0 0 000 00
fence    0ff0000f 0 00 0 0 0 00 1f 00 0 0 0 0 0 0 00000000 2 0 0 0 0 0 0 0ff 00
zero     00000000 0 00 0 0 0 00 00 00 0 0 0 0 0 0 00000000 2 0 0 0 0 0 0 000 00

// ==== testbench/instr_decoder_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_decoder_tb
    import rv_decode_pkg::*;
();

    localparam int DRIVE_DELAY = 2;                         // ns after the rising edge
    localparam int RST_TIMEOUT = 10;                        // Cycles allowed for reset release
    localparam int MAX_LINES   = 100;                       // Bound on the read loop

    logic                  clk_i;
    logic                  rst_i;
    logic [XLEN-1:0]       instr_i;
    logic                  branch_i;

    alu_op_t               alu_op;
    data_origin_e          data_origin;
    logic [1:0]            data_target;
    logic                  regfile_wr;
    logic [REG_ADDR_W-1:0] raddr_rs1;
    logic [REG_ADDR_W-1:0] raddr_rs2;
    logic [REG_ADDR_W-1:0] waddr;
    logic                  data_rd;
    logic                  data_wr;
    logic                  is_load_store;
    logic                  i_r1;
    logic                  i_r2;
    logic                  jalr;
    logic [XLEN-1:0]       imm_val;
    load_op_e              load_op;
    store_op_e             store_op;
    logic [BE_W-1:0]       data_be;
    br_op_e                br_op;
    logic                  brj;
    logic                  csr_wr;
    csr_op_t               csr_op;
    logic [CSR_ADDR_W-1:0] csr_raddr;
    logic [REG_ADDR_W-1:0] csr_imm;

    int                    error_count;
    int                    vector_count;

    // Current vector as read from one line of the stimulus file
    logic [8*16-1:0]       tag_raw;
    logic [XLEN-1:0]       exp_instr;
    logic                  exp_branch;
    alu_op_t               exp_alu;
    logic [1:0]            exp_origin;
    logic [1:0]            exp_target;
    logic                  exp_rf_wr;
    logic [REG_ADDR_W-1:0] exp_rs1;
    logic [REG_ADDR_W-1:0] exp_rs2;
    logic [REG_ADDR_W-1:0] exp_rd;
    logic                  exp_data_rd;
    logic                  exp_data_wr;
    logic                  exp_ls;
    logic                  exp_ir1;
    logic                  exp_ir2;
    logic                  exp_jalr;
    logic [XLEN-1:0]       exp_imm;
    logic [2:0]            exp_load;
    logic [1:0]            exp_store;
    logic [BE_W-1:0]       exp_be;
    logic [2:0]            exp_br;
    logic                  exp_brj;
    logic                  exp_csr_wr;
    csr_op_t               exp_csr_op;
    logic [CSR_ADDR_W-1:0] exp_csr_addr;
    logic [REG_ADDR_W-1:0] exp_csr_imm;

    tb_clock #(
        .PERIOD_NS  (20),
        .RST_CYCLES (3)
    ) i_tb_clock (
        .clk_o (clk_i),
        .rst_o (rst_i)
    );

    instr_decoder #(
        .XLEN (XLEN)
    ) i_instr_decoder (
        .instr_i             (instr_i),
        .branch_i            (branch_i),
        .alu_op_o            (alu_op),
        .data_origin_o       (data_origin),
        .data_target_o       (data_target),
        .regfile_wr_o        (regfile_wr),
        .regfile_raddr_rs1_o (raddr_rs1),
        .regfile_raddr_rs2_o (raddr_rs2),
        .regfile_waddr_o     (waddr),
        .data_rd_o           (data_rd),
        .data_wr_o           (data_wr),
        .is_load_store_o     (is_load_store),
        .i_r1_o              (i_r1),
        .i_r2_o              (i_r2),
        .jalr_o              (jalr),
        .imm_val_o           (imm_val),
        .load_op_o           (load_op),
        .store_op_o          (store_op),
        .data_be_o           (data_be),
        .br_op_o             (br_op),
        .brj_o               (brj),
        .csr_wr_o            (csr_wr),
        .csr_op_o            (csr_op),
        .csr_raddr_o         (csr_raddr),
        .csr_imm_o           (csr_imm)
    );

    task automatic report_error(input string tag, input string field,
                                input string exp_s, input string act_s);
        $display("error %0s %0s expected %0s actual %0s", tag, field, exp_s, act_s);
        error_count++;
    endtask

    task automatic compare_alu(input string tag, input alu_op_t exp_v, input alu_op_t act_v);
        if (exp_v !== act_v)
            report_error(tag, "alu_op", $sformatf("%h", exp_v), $sformatf("%h", act_v));
    endtask

    task automatic compare_origin(input string tag, input data_origin_e exp_v,
                                  input data_origin_e act_v);
        if (exp_v !== act_v)
            report_error(tag, "data_origin", $sformatf("%h", exp_v), $sformatf("%h", act_v));
    endtask

    task automatic compare_target(input string tag, input logic [1:0] exp_v,
                                  input logic [1:0] act_v);
        if (exp_v !== act_v)
            report_error(tag, "data_target", $sformatf("%h", exp_v), $sformatf("%h", act_v));
    endtask

    task automatic compare_reg(input string tag, input string field,
                               input logic [REG_ADDR_W-1:0] exp_v,
                               input logic [REG_ADDR_W-1:0] act_v);
        if (exp_v !== act_v)
            report_error(tag, field, $sformatf("%h", exp_v), $sformatf("%h", act_v));
    endtask

    task automatic compare_imm(input string tag, input logic [XLEN-1:0] exp_v,
                               input logic [XLEN-1:0] act_v);
        if (exp_v !== act_v)
            report_error(tag, "imm_val", $sformatf("%h", exp_v), $sformatf("%h", act_v));
    endtask

    task automatic compare_load(input string tag, input load_op_e exp_v, input load_op_e act_v);
        if (exp_v !== act_v)
            report_error(tag, "load_op", $sformatf("%h", exp_v), $sformatf("%h", act_v));
    endtask

    task automatic compare_store(input string tag, input store_op_e exp_v,
                                 input store_op_e act_v);
        if (exp_v !== act_v)
            report_error(tag, "store_op", $sformatf("%h", exp_v), $sformatf("%h", act_v));
    endtask

    task automatic compare_be(input string tag, input logic [BE_W-1:0] exp_v,
                              input logic [BE_W-1:0] act_v);
        if (exp_v !== act_v)
            report_error(tag, "data_be", $sformatf("%h", exp_v), $sformatf("%h", act_v));
    endtask

    task automatic compare_br(input string tag, input br_op_e exp_v, input br_op_e act_v);
        if (exp_v !== act_v)
            report_error(tag, "br_op", $sformatf("%h", exp_v), $sformatf("%h", act_v));
    endtask

    task automatic compare_csr(input string tag, input csr_op_t exp_v, input csr_op_t act_v);
        if (exp_v !== act_v)
            report_error(tag, "csr_op", $sformatf("%h", exp_v), $sformatf("%h", act_v));
    endtask

    task automatic compare_csr_addr(input string tag, input logic [CSR_ADDR_W-1:0] exp_v,
                                    input logic [CSR_ADDR_W-1:0] act_v);
        if (exp_v !== act_v)
            report_error(tag, "csr_raddr", $sformatf("%h", exp_v), $sformatf("%h", act_v));
    endtask

    task automatic compare_bit(input string tag, input string field,
                               input logic exp_v, input logic act_v);
        if (exp_v !== act_v)
            report_error(tag, field, $sformatf("%b", exp_v), $sformatf("%b", act_v));
    endtask

    // Splits one vector line into the expected fields and returns the field count
    function automatic int parse_vector(input string line);
        return $sscanf(line,
            "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            tag_raw, exp_instr, exp_branch, exp_alu, exp_origin, exp_target, exp_rf_wr,
            exp_rs1, exp_rs2, exp_rd, exp_data_rd, exp_data_wr, exp_ls, exp_ir1, exp_ir2,
            exp_jalr, exp_imm, exp_load, exp_store, exp_be, exp_br, exp_brj, exp_csr_wr,
            exp_csr_op, exp_csr_addr, exp_csr_imm);
    endfunction

    task automatic check_outputs(input string tag);
        compare_alu(tag, exp_alu, alu_op);
        compare_origin(tag, data_origin_e'(exp_origin), data_origin);
        compare_target(tag, exp_target, data_target);
        compare_bit(tag, "regfile_wr", exp_rf_wr, regfile_wr);
        compare_reg(tag, "raddr_rs1", exp_rs1, raddr_rs1);
        compare_reg(tag, "raddr_rs2", exp_rs2, raddr_rs2);
        compare_reg(tag, "waddr", exp_rd, waddr);
        compare_bit(tag, "data_rd", exp_data_rd, data_rd);
        compare_bit(tag, "data_wr", exp_data_wr, data_wr);
        compare_bit(tag, "is_load_store", exp_ls, is_load_store);
        compare_bit(tag, "i_r1", exp_ir1, i_r1);
        compare_bit(tag, "i_r2", exp_ir2, i_r2);
        compare_bit(tag, "jalr", exp_jalr, jalr);
        compare_imm(tag, exp_imm, imm_val);
        compare_load(tag, load_op_e'(exp_load), load_op);
        compare_store(tag, store_op_e'(exp_store), store_op);
        compare_be(tag, exp_be, data_be);
        compare_br(tag, br_op_e'(exp_br), br_op);
        compare_bit(tag, "brj", exp_brj, brj);
        compare_bit(tag, "csr_wr", exp_csr_wr, csr_wr);
        compare_csr(tag, exp_csr_op, csr_op);
        compare_csr_addr(tag, exp_csr_addr, csr_raddr);
        compare_reg(tag, "csr_imm", exp_csr_imm, csr_imm);
    endtask

    task automatic run_vectors();
        int    fd;
        int    got;
        int    n_items;
        int    line_count;
        string line;
        fd = $fopen("testbench/decode_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/decode_stimulus.txt for reading");
            error_count++;
        end else begin
            line_count = 0;
            while (!$feof(fd) && line_count < MAX_LINES) begin
                line_count++;
                line = "";
                got  = $fgets(line, fd);
                if (got != 0 && line.len() > 1 && line.getc(0) != "#") begin
                    n_items = parse_vector(line);
                    if (n_items != 26) begin
                        $display("line %0d of the stimulus file holds %0d fields, not 26",
                                 line_count, n_items);
                        error_count++;
                    end else begin
                        @(posedge clk_i);
                        #DRIVE_DELAY;                       // Clear of the clock edge
                        instr_i  = exp_instr;
                        branch_i = exp_branch;
                        @(negedge clk_i);                   // Outputs settled by now
                        check_outputs(string'(tag_raw));
                        vector_count++;
                    end
                end
            end
            if (!$feof(fd)) begin
                $display("stimulus file not at its end after %0d lines", MAX_LINES);
                error_count++;
            end
            $fclose(fd);
        end
    endtask

    initial begin
        int wait_cycles;
        instr_i      = '0;                                  // All-zero word decodes to defaults
        branch_i     = 1'b0;
        error_count  = 0;
        vector_count = 0;
        wait_cycles  = 0;
        while (rst_i !== 1'b0 && wait_cycles < RST_TIMEOUT) begin
            @(negedge clk_i);
            wait_cycles++;
        end
        if (rst_i !== 1'b0) begin
            $display("reset still asserted after %0d cycles", RST_TIMEOUT);
            error_count++;
        end else begin
            run_vectors();
        end
        if (vector_count == 0) begin
            $display("no test vectors were applied");
            error_count++;
        end
        $display("vectors %0d errors %0d", vector_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;            // Free running
    end

    initial begin
        rst_o <= 1'b1;                                      // Asserted from time zero
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;                                      // Drops on the third rising edge
    end

endmodule

`default_nettype wire
